//--- hdl/game_fsm.sv
`default_nettype none

module game_fsm
    import screen_pkg::*;
    import game_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  coord_t x_i,
    input  coord_t y_i,
    input  key_t   key_pulse_i,
    input  logic   miss_i,
    output logic   move_o,
    output logic   park_o,
    output logic   restore_o,
    output lives_t lives_o,
    output logic   game_over_o
);

    game_state_t state_q, state_d;
    lives_t      lives_q, lives_d;
    logic        tick;
    logic        start;

    // last visible pixel marks the end of a frame
    assign tick  = (x_i == coord_t'(MAX_X - 1)) && (y_i == coord_t'(MAX_Y - 1));
    assign start = (key_pulse_i == KEY_START);

    //////////////////////////////////////////////////////////////////////
    // next state
    always_comb begin
        state_d = state_q;
        lives_d = lives_q;
        case (state_q)
            ST_NEWGAME: begin
                if (start) begin
                    state_d = ST_PLAY;
                    lives_d = LIVES_START;
                end
            end
            ST_PLAY: begin
                if (miss_i) begin
                    lives_d = lives_t'(lives_q - 2'd1);
                    state_d = (lives_q == 2'd1) ? ST_OVER : ST_NEWGUN; // last life gone
                end
            end
            ST_NEWGUN: if (start) state_d = ST_PLAY;
            ST_OVER: begin
                if (start) begin
                    state_d = ST_NEWGAME;
                    lives_d = LIVES_START;  // refill for the next game
                end
            end
            default: state_d = ST_NEWGAME;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_NEWGAME;
            lives_q <= LIVES_START;
        end else begin
            state_q <= state_d;
            lives_q <= lives_d;
        end
    end

    // strobes for the data path
    assign move_o      = tick && (state_q == ST_PLAY);
    assign park_o      = (state_q != ST_PLAY);
    assign restore_o   = (state_q == ST_NEWGAME);
    assign lives_o     = lives_q;
    assign game_over_o = (state_q == ST_OVER);

endmodule

`default_nettype wire

//--- hdl/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef logic [4:0] key_t;

    // held levels on key_i
    localparam key_t KEY_RIGHT = 5'h11;
    localparam key_t KEY_LEFT  = 5'h13;

    // one-cycle codes on key_pulse_i
    localparam key_t KEY_FIRE  = 5'h15;
    localparam key_t KEY_START = 5'h10;

    typedef enum logic [1:0] {
        ST_NEWGAME = 2'd0,
        ST_PLAY    = 2'd1,
        ST_NEWGUN  = 2'd2,
        ST_OVER    = 2'd3
    } game_state_t;

    typedef logic [1:0] lives_t;
    localparam lives_t LIVES_START = 2'd3;

    typedef logic [3:0] bcd_t;      // one decimal digit

endpackage

`default_nettype wire

//--- hdl/gun_ctrl.sv
`default_nettype none

module gun_ctrl
    import screen_pkg::*;
    import game_pkg::*;
#(
    parameter int GUN_V  = 4,
    parameter int SHOT_V = 7
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   move_i,
    input  logic   park_i,
    input  logic   hit_i,
    input  key_t   key_i,
    input  key_t   key_pulse_i,
    output coord_t gun_x_o,
    output coord_t shot_x_o,
    output coord_t shot_y_o,
    output logic   shot_active_o,
    output logic   miss_o
);

    localparam coord_t SHOT_DX = coord_t'(GUN_W / 2 - 3);       // launch offset from gun left
    localparam coord_t SHOT_Y0 = coord_t'(GUN_Y_T - SHOT_SIZE); // just above the gun
    localparam coord_t GUN_R_LIM = coord_t'(MAX_X - GUN_W - GUN_V);

    coord_t gun_x_q;
    coord_t shot_x_q;
    coord_t shot_y_q;
    logic   shot_act_q;
    logic   fire_q;
    logic   at_top;

    assign at_top = shot_act_q && (shot_y_q < coord_t'(SHOT_V));
    assign miss_o = move_i && at_top && !hit_i;     // a hit takes precedence

    //////////////////////////////////////////////////////////////////////
    // gun position, fire latch, shot state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gun_x_q    <= coord_t'(GUN_X0);
            shot_act_q <= 1'b0;
            fire_q     <= 1'b0;
        end else if (park_i) begin
            gun_x_q    <= coord_t'(GUN_X0);
            shot_act_q <= 1'b0;
            fire_q     <= 1'b0;
        end else begin
            if (key_pulse_i == KEY_FIRE && !shot_act_q)
                fire_q <= 1'b1;                     // dropped while in flight
            if (move_i) begin
                if (shot_act_q) begin
                    if (hit_i || at_top)
                        shot_act_q <= 1'b0;
                end else if (fire_q) begin
                    shot_act_q <= 1'b1;
                    fire_q     <= 1'b0;
                end
                if (key_i == KEY_RIGHT && gun_x_q <= GUN_R_LIM)
                    gun_x_q <= gun_x_q + coord_t'(GUN_V);
                else if (key_i == KEY_LEFT && gun_x_q >= coord_t'(GUN_V))
                    gun_x_q <= gun_x_q - coord_t'(GUN_V);
            end
        end
    end

    // shot position, only meaningful while active
    always_ff @(posedge clk) begin
        if (move_i) begin
            if (shot_act_q) begin
                shot_y_q <= shot_y_q - coord_t'(SHOT_V);
            end else begin
                shot_x_q <= gun_x_q + SHOT_DX;      // gun before this frame's move
                shot_y_q <= SHOT_Y0;
            end
        end
    end

    assign gun_x_o       = gun_x_q;
    assign shot_x_o      = shot_x_q;
    assign shot_y_o      = shot_y_q;
    assign shot_active_o = shot_act_q;

endmodule

`default_nettype wire

//--- hdl/obstacle_row.sv
`default_nettype none

module obstacle_row
    import screen_pkg::*;
#(
    parameter int NUM_OBS = 10
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               move_i,
    input  logic               restore_i,
    input  coord_t             shot_x_i,
    input  coord_t             shot_y_i,
    input  logic               shot_active_i,
    output logic [NUM_OBS-1:0] alive_o,
    output logic               hit_o
);

    logic [NUM_OBS-1:0] alive_q;
    logic [NUM_OBS-1:0] hit_vec;    // one-hot, lowest index wins

    //////////////////////////////////////////////////////////////////////
    // shot box against each live obstacle box
    always_comb begin
        int   sx;
        int   sy;
        int   ol;
        logic found;
        hit_vec = '0;
        found   = 1'b0;
        sx      = int'(shot_x_i);
        sy      = int'(shot_y_i);
        for (int i = 0; i < NUM_OBS; i++) begin
            ol = obs_left(i);
            if (!found && shot_active_i && alive_q[i]
                && sx <= ol + OBS_SIZE - 1 && sx + SHOT_SIZE - 1 >= ol
                && sy <= OBS_Y + OBS_SIZE - 1 && sy + SHOT_SIZE - 1 >= OBS_Y) begin
                hit_vec[i] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    assign hit_o = move_i && (|hit_vec);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alive_q <= '1;
        end else if (restore_i || alive_q == '0) begin
            alive_q <= '1;                  // new game or row cleared
        end else if (hit_o) begin
            alive_q <= alive_q & ~hit_vec;
        end
    end

    assign alive_o = alive_q;

endmodule

`default_nettype wire

//--- hdl/pixel_mux.sv
`default_nettype none

module pixel_mux
    import screen_pkg::*;
#(
    parameter int NUM_OBS = 10
) (
    input  logic               clk,
    input  logic               rst,
    input  coord_t             x_i,
    input  coord_t             y_i,
    input  coord_t             gun_x_i,
    input  coord_t             shot_x_i,
    input  coord_t             shot_y_i,
    input  logic               shot_active_i,
    input  logic [NUM_OBS-1:0] alive_i,
    output rgb_t               rgb_o
);

    logic shot_on;
    logic gun_on;
    logic obs_on;

    assign shot_on = shot_active_i
                     && x_i >= shot_x_i && x_i <= shot_x_i + coord_t'(SHOT_SIZE - 1)
                     && y_i >= shot_y_i && y_i <= shot_y_i + coord_t'(SHOT_SIZE - 1);

    assign gun_on = x_i >= gun_x_i && x_i <= gun_x_i + coord_t'(GUN_W - 1)
                    && y_i >= coord_t'(GUN_Y_T) && y_i <= coord_t'(GUN_Y_B);

    always_comb begin
        int px;
        int py;
        int ol;
        px     = int'(x_i);
        py     = int'(y_i);
        obs_on = 1'b0;
        for (int i = 0; i < NUM_OBS; i++) begin
            ol = obs_left(i);
            if (alive_i[i] && px >= ol && px <= ol + OBS_SIZE - 1
                && py >= OBS_Y && py <= OBS_Y + OBS_SIZE - 1)
                obs_on = 1'b1;
        end
    end

    // shot over gun over obstacles
    always_ff @(posedge clk or posedge rst) begin
        if (rst)          rgb_o <= RGB_BLACK;
        else if (shot_on) rgb_o <= RGB_RED;
        else if (gun_on)  rgb_o <= RGB_WHITE;
        else if (obs_on)  rgb_o <= RGB_BLUE;
        else              rgb_o <= RGB_BLACK;
    end

endmodule

`default_nettype wire

//--- hdl/score_counter.sv
`default_nettype none

module score_counter
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       clear_i,
    input  logic       inc_i,
    output bcd_t [1:0] score_o      // [1] tens, [0] units
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            score_o <= '0;
        end else if (clear_i) begin
            score_o <= '0;
        end else if (inc_i) begin
            if (score_o[0] == 4'd9) begin
                score_o[0] <= 4'd0;             // carry into tens
                if (score_o[1] == 4'd9) begin
                    score_o[1] <= 4'd0;         // 99 wraps to 00
                end else begin
                    score_o[1] <= bcd_t'(score_o[1] + 4'd1);
                end
            end else begin
                score_o[0] <= bcd_t'(score_o[0] + 4'd1);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/screen_pkg.sv
`default_nettype none

package screen_pkg;

    typedef logic [9:0] coord_t;    // raster coordinate
    typedef logic [2:0] rgb_t;      // r, g, b

    // visible raster
    localparam int MAX_X = 640;
    localparam int MAX_Y = 480;

    // gun box, parked in the middle of the bottom row
    localparam int GUN_W   = 50;
    localparam int GUN_Y_T = 420;
    localparam int GUN_Y_B = 470;
    localparam int GUN_X0  = (MAX_X - GUN_W) / 2;   // 295

    localparam int SHOT_SIZE = 6;   // square shot

    // obstacle row
    localparam int OBS_SIZE  = 30;
    localparam int OBS_X0    = 20;
    localparam int OBS_PITCH = 64;
    localparam int OBS_Y     = 150;

    localparam rgb_t RGB_BLACK = 3'b000;
    localparam rgb_t RGB_BLUE  = 3'b001;
    localparam rgb_t RGB_RED   = 3'b100;
    localparam rgb_t RGB_WHITE = 3'b111;

    // left edge of obstacle i
    function automatic int obs_left(input int i);
        return OBS_X0 + i * OBS_PITCH;
    endfunction

endpackage

`default_nettype wire

//--- hdl/shooter_top.sv
`default_nettype none

module shooter_top
    import screen_pkg::*;
    import game_pkg::*;
#(
    parameter int NUM_OBS = 10,
    parameter int GUN_V   = 4,
    parameter int SHOT_V  = 7
) (
    input  logic       clk,
    input  logic       rst,
    input  coord_t     x_i,
    input  coord_t     y_i,
    input  key_t       key_i,
    input  key_t       key_pulse_i,
    output rgb_t       rgb_o,
    output bcd_t [1:0] score_o,
    output lives_t     lives_o,
    output logic       game_over_o
);

    logic               move, park, restore;
    logic               miss, hit;
    coord_t             gun_x, shot_x, shot_y;
    logic               shot_active;
    logic [NUM_OBS-1:0] alive;

    //////////////////////////////////////////////////////////////////////
    // control
    game_fsm u_fsm (
        .clk, .rst, .x_i, .y_i, .key_pulse_i,
        .miss_i      (miss),
        .move_o      (move),
        .park_o      (park),
        .restore_o   (restore),
        .lives_o, .game_over_o
    );

    score_counter u_score (
        .clk, .rst,
        .clear_i (restore),
        .inc_i   (hit),
        .score_o
    );

    //////////////////////////////////////////////////////////////////////
    // data path
    gun_ctrl #(.GUN_V(GUN_V), .SHOT_V(SHOT_V)) u_gun (
        .clk, .rst,
        .move_i (move), .park_i (park), .hit_i (hit),
        .key_i, .key_pulse_i,
        .gun_x_o (gun_x), .shot_x_o (shot_x), .shot_y_o (shot_y),
        .shot_active_o (shot_active), .miss_o (miss)
    );

    obstacle_row #(.NUM_OBS(NUM_OBS)) u_obs (
        .clk, .rst,
        .move_i (move), .restore_i (restore),
        .shot_x_i (shot_x), .shot_y_i (shot_y), .shot_active_i (shot_active),
        .alive_o (alive), .hit_o (hit)
    );

    pixel_mux #(.NUM_OBS(NUM_OBS)) u_pix (
        .clk, .rst, .x_i, .y_i,
        .gun_x_i (gun_x), .shot_x_i (shot_x), .shot_y_i (shot_y),
        .shot_active_i (shot_active), .alive_i (alive),
        .rgb_o
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps --top-module shooter_tb \
    -f shooter_top.f -o shooter_sim \
    && ./obj_dir/shooter_sim | tee sim.log \
    || { echo "build or run failed"; exit 1; }
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- shooter_top.f
hdl/screen_pkg.sv
hdl/game_pkg.sv
hdl/score_counter.sv
hdl/game_fsm.sv
hdl/gun_ctrl.sv
hdl/obstacle_row.sv
hdl/pixel_mux.sv
hdl/shooter_top.sv
verif/shooter_tb.sv

//--- verif/shooter_tb.sv
`default_nettype none

module shooter_tb
    import screen_pkg::*;
    import game_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OBS     = 10;
    localparam int GUN_V       = 4;
    localparam int SHOT_V      = 7;
    localparam int WATCHDOG_NS = 400 * 20 * 100;   // 400 frames of 20 cycles

    logic       clk = 1'b0;
    logic       rst;
    coord_t     x_i;
    coord_t     y_i;
    key_t       key_i;
    key_t       key_pulse_i;
    rgb_t       rgb_o;
    bcd_t [1:0] score_o;
    lives_t     lives_o;
    logic       game_over_o;

    // testbench copy of the game
    game_state_t        m_state;
    int                 m_lives, m_score, m_gun_x, m_shot_x, m_shot_y;
    logic               m_act, m_fire;
    logic [NUM_OBS-1:0] m_alive;
    key_t               held;

    logic   chk_req, chk_rgb;
    rgb_t   exp_rgb;
    int     errors, checks;
    integer seed;

    shooter_top #(.NUM_OBS(NUM_OBS), .GUN_V(GUN_V), .SHOT_V(SHOT_V)) u_dut (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reference model
    function automatic rgb_t model_rgb(input int x, input int y);
        int left;
        if (m_act && x >= m_shot_x && x < m_shot_x + SHOT_SIZE
            && y >= m_shot_y && y < m_shot_y + SHOT_SIZE)
            return RGB_RED;
        if (x >= m_gun_x && x < m_gun_x + GUN_W && y >= GUN_Y_T && y <= GUN_Y_B)
            return RGB_WHITE;
        for (int i = 0; i < NUM_OBS; i++) begin
            left = OBS_X0 + i * OBS_PITCH;
            if (m_alive[i] && x >= left && x < left + OBS_SIZE
                && y >= OBS_Y && y < OBS_Y + OBS_SIZE)
                return RGB_BLUE;
        end
        return RGB_BLACK;
    endfunction

    function automatic void park();
        m_gun_x = 295;      // centred gun
        m_act   = 1'b0;
        m_fire  = 1'b0;
    endfunction

    // one move strobe on the copy
    function automatic void apply_frame();
        int   victim;
        int   left;
        logic missed;
        victim = -1;
        missed = 1'b0;
        for (int i = NUM_OBS - 1; i >= 0; i--) begin
            left = OBS_X0 + i * OBS_PITCH;
            if (m_act && m_alive[i] && m_shot_x < left + OBS_SIZE && m_shot_x + SHOT_SIZE > left
                && m_shot_y < OBS_Y + OBS_SIZE && m_shot_y + SHOT_SIZE > OBS_Y)
                victim = i;     // lowest index wins
        end
        if (victim >= 0) begin
            m_alive[victim] = 1'b0;
            m_act           = 1'b0;
            m_score         = (m_score + 1) % 100;
        end else if (m_act && m_shot_y < SHOT_V) begin
            m_act  = 1'b0;
            missed = 1'b1;
        end else if (m_act) begin
            m_shot_y -= SHOT_V;
        end else if (m_fire) begin
            m_act    = 1'b1;
            m_fire   = 1'b0;
            m_shot_x = m_gun_x + GUN_W / 2 - 3;
            m_shot_y = GUN_Y_T - SHOT_SIZE;
        end
        if (held == KEY_RIGHT && m_gun_x + GUN_W + GUN_V <= MAX_X)
            m_gun_x += GUN_V;
        else if (held == KEY_LEFT && m_gun_x >= GUN_V)
            m_gun_x -= GUN_V;
        if (m_alive == '0)
            m_alive = '1;   // row comes back
        if (missed) begin
            m_lives--;
            m_state = (m_lives == 0) ? ST_OVER : ST_NEWGUN;
            park();
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    task automatic step(input int x, input int y, input key_t pulse);
        @(posedge clk);
        #10;
        x_i         = coord_t'(x);
        y_i         = coord_t'(y);
        key_i       = held;
        key_pulse_i = pulse;
    endtask

    task automatic request(input logic with_rgb, input rgb_t rgb);
        chk_rgb = with_rgb;
        exp_rgb = rgb;
        chk_req = 1'b1;
    endtask

    // colour shows one cycle after the pixel
    task automatic look(input int x, input int y);
        step(x, y, '0);
        step(0, 0, '0);
        request(1'b1, model_rgb(x, y));
    endtask

    task automatic look_gun();
        look(m_gun_x - 1, 445);
        look(m_gun_x, 445);
        look(m_gun_x + GUN_W - 1, 445);
        look(m_gun_x + GUN_W, 445);
    endtask

    task automatic frame();
        step(MAX_X - 1, MAX_Y - 1, '0);     // tick pixel
        step(0, 0, '0);
        if (m_state == ST_PLAY)
            apply_frame();
        request(1'b0, RGB_BLACK);
    endtask

    task automatic slide(input key_t dir, input int frames);
        held = dir;
        repeat (frames) frame();
        held = '0;
    endtask

    task automatic fire();
        step(0, 0, KEY_FIRE);
        if (m_state == ST_PLAY && !m_act)
            m_fire = 1'b1;
    endtask

    task automatic start();
        step(0, 0, KEY_START);
        step(0, 0, '0);
        step(0, 0, '0);     // score clears a cycle into new game
        case (m_state)
            ST_NEWGAME: begin
                m_state = ST_PLAY;
                m_lives = LIVES_START;
            end
            ST_NEWGUN: m_state = ST_PLAY;
            ST_OVER: begin
                m_state = ST_NEWGAME;
                m_lives = LIVES_START;
                m_score = 0;
                m_alive = '1;
            end
            default: ;
        endcase
        request(1'b0, RGB_BLACK);
    endtask

    // fire and follow the shot until it hits or leaves the top
    task automatic shoot();
        int rx;
        int ry;
        fire();
        for (int n = 0; n < 100 && (m_act || m_fire); n++) begin
            frame();
            if (m_act)
                look(m_shot_x + 2, m_shot_y + 2);
            rx = {$random(seed)} % MAX_X;
            ry = {$random(seed)} % MAX_Y;
            look(rx, ry);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare, half a cycle after the inputs settle
    always @(negedge clk) begin
        if (chk_req) begin
            chk_req = 1'b0;
            checks++;
            if (score_o !== {bcd_t'(m_score / 10), bcd_t'(m_score % 10)}) begin
                errors++;
                $display("ERROR at %0t: score %h, expected %0d", $time, score_o, m_score);
            end
            if (lives_o !== lives_t'(m_lives)) begin
                errors++;
                $display("ERROR at %0t: lives %0d, expected %0d", $time, lives_o, m_lives);
            end
            if (game_over_o !== (m_state == ST_OVER)) begin
                errors++;
                $display("ERROR at %0t: game_over_o %b, wrong for state %s",
                         $time, game_over_o, m_state.name());
            end
            if (chk_rgb && rgb_o !== exp_rgb) begin
                errors++;
                $display("ERROR at %0t: rgb %b, expected %b", $time, rgb_o, exp_rgb);
            end
        end
    end

    initial begin
        seed        = 87541;
        errors      = 0;
        checks      = 0;
        rst         = 1'b1;
        x_i         = '0;
        y_i         = '0;
        key_i       = '0;
        key_pulse_i = '0;
        held        = '0;
        chk_req     = 1'b0;
        chk_rgb     = 1'b0;
        exp_rgb     = RGB_BLACK;
        m_state     = ST_NEWGAME;
        m_lives     = LIVES_START;
        m_score     = 0;
        m_shot_x    = 0;
        m_shot_y    = 0;
        m_alive     = '1;
        park();
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        request(1'b1, RGB_BLACK);

        // reset picture
        look(m_gun_x + GUN_W / 2, 445);
        look(5, 5);
        look(630, 300);
        for (int i = 0; i < NUM_OBS; i++)
            look(OBS_X0 + i * OBS_PITCH + 15, OBS_Y + 15);

        // gun runs into both edges
        start();
        slide(KEY_RIGHT, 76);
        look_gun();
        slide(KEY_LEFT, 150);
        look_gun();

        // clear the row left to right, score carries to 10
        for (int i = 0; i < NUM_OBS; i++) begin
            if (i > 0)
                slide(KEY_RIGHT, OBS_PITCH / GUN_V);
            shoot();
            look(OBS_X0 + i * OBS_PITCH + 15, OBS_Y + 15);
        end
        for (int i = 0; i < NUM_OBS; i++)
            look(OBS_X0 + i * OBS_PITCH + 15, OBS_Y + 15);

        // misses until game over
        shoot();                    // obstacle 9 dies again
        shoot();                    // straight through its empty box
        look(m_gun_x + GUN_W / 2, 445);
        start();
        shoot();                    // parked gun fires between 4 and 5
        start();
        shoot();
        start();                    // over to new game
        start();                    // and into play
        look(m_gun_x + GUN_W / 2, 445);
        slide(KEY_RIGHT, 1);        // gun only moves in play
        look_gun();
        step(0, 0, '0);

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
